//--- bench/iotdf_input.txt
# fn  data (128-bit hex)  expected result (128-bit hex)
# fn 3 is CRC-3, 4 binary to Gray, 5 Gray to binary, other codes give no result
3 00000000000000000000000000000000 00000000000000000000000000000000
3 ffffffffffffffffffffffffffffffff 00000000000000000000000000000005
3 00000000000000000000000000000001 00000000000000000000000000000003
1 0123456789abcdeffedcba9876543210 00000000000000000000000000000000
3 80000000000000000000000000000000 00000000000000000000000000000006
4 00000000000000000000000000000100 00000000000000000000000000000180
5 00000000000000000000000000000180 00000000000000000000000000000100
4 0123456789abcdeffedcba9876543210 01b2e7d44d7e2b1801b2e7d44d7e2b18
2 deadbeefcafef00d0badc0de12345678 00000000000000000000000000000000
5 01b2e7d44d7e2b1801b2e7d44d7e2b18 0123456789abcdeffedcba9876543210
4 ffffffffffffffffffffffffffffffff 80000000000000000000000000000000
7 5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a 00000000000000000000000000000000
5 80000000000000000000000000000000 ffffffffffffffffffffffffffffffff
3 00000000000000000000000000000005 00000000000000000000000000000004

//--- bench/iotdf_tb.sv
`timescale 1ns/1ps

module iotdf_tb import iotdf_pkg::*; ();

	logic                  clk;
	logic                  rst;
	logic                  in_en;
	logic [BYTE_WIDTH-1:0] iot_in;
	logic [FN_WIDTH-1:0]   fn_sel;
	logic                  busy;
	logic                  valid;
	result_word_u          iot_out;

	// Vectors from the input file
	logic [FN_WIDTH-1:0]   vec_fn[$];
	logic [WORD_WIDTH-1:0] vec_data[$];
	logic [WORD_WIDTH-1:0] vec_exp[$];

	// Results still owed by the DUT, in block order
	logic [FN_WIDTH-1:0]   fn_q[$];
	logic [WORD_WIDTH-1:0] exp_q[$];
	int                    due_q[$];

	logic [31:0] rng_state = 32'd13519;
	logic        rst_q = 1'b1;
	int          cycle = 0;
	int          limit = 0;

	iotdf #(
		.CRC_POLY (3'b011)
	) dut (
		.clk     (clk),
		.rst     (rst),
		.in_en   (in_en),
		.iot_in  (iot_in),
		.fn_sel  (fn_sel),
		.busy    (busy),
		.valid   (valid),
		.iot_out (iot_out)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// --------------------------------------------------
	// Helpers
	// --------------------------------------------------
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic is_supported(input logic [FN_WIDTH-1:0] fn);
		return (fn == FN_CRC) || (fn == FN_B2G) || (fn == FN_G2B);
	endfunction

	task automatic stop_on_failure();
		$display("RESULT: FAIL");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("FAILED at %0t: %s expected %0b, got %0b", $time, name, exp, act);
			stop_on_failure();
		end
	endtask

	task automatic check_word(input result_word_u exp, input result_word_u act);
		if (act.raw !== exp.raw) begin
			$display("FAILED at %0t: iot_out.raw expected %h, got %h", $time, exp.raw, act.raw);
			stop_on_failure();
		end
	endtask

	task automatic check_crc(input logic [CRC_WIDTH-1:0] exp, input result_word_u act);
		if (act.crc_view.crc_pad !== '0) begin
			$display("FAILED at %0t: iot_out.crc_view.crc_pad expected 0, got %h",
				$time, act.crc_view.crc_pad);
			stop_on_failure();
		end else if (act.crc_view.crc_rem !== exp) begin
			$display("FAILED at %0t: iot_out.crc_view.crc_rem expected %h, got %h",
				$time, exp, act.crc_view.crc_rem);
			stop_on_failure();
		end
	endtask

	task automatic load_vectors();
		int                    fd;
		int                    rc;
		int                    bad;
		string                 line;
		logic [FN_WIDTH-1:0]   f;
		logic [WORD_WIDTH-1:0] d;
		logic [WORD_WIDTH-1:0] e;
		bad = 0;
		fd = $fopen("bench/iotdf_input.txt", "r");
		if (fd != 0) begin
			while (!$feof(fd)) begin
				line = "";
				rc = $fgets(line, fd);
				if (rc > 1 && line.substr(0, 0) != "#") begin
					rc = $sscanf(line, "%h %h %h", f, d, e);
					if (rc == 3) begin
						vec_fn.push_back(f);
						vec_data.push_back(d);
						vec_exp.push_back(e);
					end else begin
						bad++;
					end
				end
			end
			$fclose(fd);
		end
		if (fd == 0) begin
			$display("Cannot open the vector file bench/iotdf_input.txt");
			stop_on_failure();
		end else if (bad > 0 || vec_fn.size() == 0) begin
			$display("Vector file has %0d unreadable lines and %0d blocks", bad, vec_fn.size());
			stop_on_failure();
		end else begin
			limit = vec_fn.size() * BLOCK_BYTES * 3 + 50;
		end
	endtask

	// One block MSB byte first with 0 to 2 idle cycles before each byte
	task automatic drive_block(input logic [FN_WIDTH-1:0] fn, input logic [WORD_WIDTH-1:0] data,
		input logic [WORD_WIDTH-1:0] exp);
		int gap;
		for (int b = 0; b < BLOCK_BYTES; b++) begin
			rng_state = xorshift(rng_state);
			gap = int'(rng_state % 32'd3);
			repeat (gap) begin
				@(posedge clk);
				in_en <= 1'b0;
			end
			@(posedge clk);
			in_en  <= 1'b1;
			iot_in <= data[WORD_WIDTH-1-BYTE_WIDTH*b -: BYTE_WIDTH];
			// Later bytes carry noise on fn_sel
			fn_sel <= (b == 0) ? fn : rng_state[FN_WIDTH+7:8];
			if (b == BLOCK_BYTES - 1 && is_supported(fn)) begin
				fn_q.push_back(fn);
				exp_q.push_back(exp);
				// Valid shows at the falling edge two edges after the byte is sampled
				due_q.push_back(cycle + 4);
			end
		end
	endtask

	// --------------------------------------------------
	// Cycle count and timeout
	// --------------------------------------------------
	always @(posedge clk) begin
		cycle <= cycle + 1;
		rst_q <= rst;
		if (limit > 0 && cycle >= limit) begin
			$display("Timeout after %0d cycles with %0d results still missing", cycle, due_q.size());
			stop_on_failure();
		end
	end

	// Outputs are checked at the falling edge
	always @(negedge clk) begin
		logic         due_now;
		result_word_u exp_word;
		if (rst) begin
			check_flag("busy", 1'b1, busy);
		end else if (!rst_q) begin
			check_flag("busy", 1'b0, busy);
		end
		due_now = (due_q.size() > 0) && (due_q[0] == cycle);
		check_flag("valid", due_now, valid);
		if (due_now) begin
			exp_word.raw = exp_q[0];
			if (fn_q[0] == FN_CRC) begin
				check_crc(exp_word.crc_view.crc_rem, iot_out);
			end else begin
				check_word(exp_word, iot_out);
			end
			void'(fn_q.pop_front());
			void'(exp_q.pop_front());
			void'(due_q.pop_front());
		end
	end

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------
	initial begin
		rst    <= 1'b1;
		in_en  <= 1'b0;
		iot_in <= '0;
		fn_sel <= '0;
		load_vectors();
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		for (int v = 0; v < vec_fn.size(); v++) begin
			drive_block(vec_fn[v], vec_data[v], vec_exp[v]);
		end
		@(posedge clk);
		in_en <= 1'b0;
		while (due_q.size() != 0) begin
			@(posedge clk);
		end
		// A few quiet cycles to catch a stray valid
		repeat (4) @(posedge clk);
		$display("RESULT: PASS");
		$finish;
	end

endmodule

//--- iotdf.f
source/iotdf_pkg.sv
source/byte_capture.sv
source/crc_stage.sv
source/gray_stage.sv
source/result_assembler.sv
source/iotdf.sv
bench/iotdf_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f iotdf.f --top-module iotdf_tb \
	-Mdir obj_dir -o iotdf_sim

output=$(./obj_dir/iotdf_sim 2>&1 || true)
echo "$output"

if echo "$output" | grep -q "^RESULT: PASS$"; then
	exit 0
else
	exit 1
fi

//--- source/byte_capture.sv
`timescale 1ns/1ps

module byte_capture import iotdf_pkg::*; (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      in_en,
	input  logic [BYTE_WIDTH-1:0]     iot_in,
	input  logic [FN_WIDTH-1:0]       fn_sel,
	output logic                      busy,
	output logic                      cap_strobe,
	output logic [BYTE_WIDTH-1:0]     cap_byte,
	output logic                      cap_first,
	output logic                      cap_last,
	output logic [FN_WIDTH-1:0]       cap_fn,
	output logic [BYTE_IDX_WIDTH-1:0] cap_idx
);

	logic [BYTE_IDX_WIDTH-1:0] byte_cnt;
	logic                      at_first;
	logic                      at_last;

	assign at_first = (byte_cnt == '0);
	assign at_last  = (byte_cnt == BYTE_IDX_WIDTH'(BLOCK_BYTES - 1));

	// Busy only covers reset since the pipeline never stalls
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy <= 1'b1;
		end else begin
			busy <= 1'b0;
		end
	end

	// --------------------------------------------------
	// Byte counter and block markers
	// --------------------------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			byte_cnt   <= '0;
			cap_strobe <= 1'b0;
			cap_first  <= 1'b0;
			cap_last   <= 1'b0;
			cap_fn     <= '0;
			cap_idx    <= '0;
		end else begin
			cap_strobe <= in_en;
			if (in_en) begin
				// Wraps to zero after the 16th byte
				byte_cnt  <= byte_cnt + 1'b1;
				cap_first <= at_first;
				cap_last  <= at_last;
				cap_idx   <= byte_cnt;
				// Function code only taken with the first byte
				if (at_first) begin
					cap_fn <= fn_sel;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in_en) begin
			cap_byte <= iot_in;
		end
	end

	// First and last markers never coincide
	a_markers: assert property (@(posedge clk) disable iff (rst)
		cap_strobe |-> !(cap_first && cap_last))
		else $error("byte_capture: first/last markers out of step");

endmodule

//--- source/crc_stage.sv
`timescale 1ns/1ps

module crc_stage import iotdf_pkg::*; #(
	parameter logic [CRC_WIDTH-1:0] CRC_POLY = 3'b011
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  cap_strobe,
	input  logic [BYTE_WIDTH-1:0] cap_byte,
	input  logic                  cap_first,
	input  logic                  cap_last,
	input  logic [FN_WIDTH-1:0]   cap_fn,
	output logic                  crc_done,
	output logic [CRC_WIDTH-1:0]  crc_rem
);

	logic                 crc_take;
	logic [CRC_WIDTH-1:0] rem_start;
	logic [CRC_WIDTH-1:0] rem_next;

	// Long division, one data bit per step, MSB first
	function automatic logic [CRC_WIDTH-1:0] crc_fold(
		input logic [CRC_WIDTH-1:0]  rem_in,
		input logic [BYTE_WIDTH-1:0] data,
		input logic                  close
	);
		logic [CRC_WIDTH-1:0] rem;
		logic                 top;
		rem = rem_in;
		for (int i = BYTE_WIDTH - 1; i >= 0; i--) begin
			top = rem[CRC_WIDTH-1];
			rem = {rem[CRC_WIDTH-2:0], data[i]} ^ ({CRC_WIDTH{top}} & CRC_POLY);
		end
		// Append x^3 worth of zeros after the final byte
		if (close) begin
			for (int j = 0; j < CRC_WIDTH; j++) begin
				top = rem[CRC_WIDTH-1];
				rem = {rem[CRC_WIDTH-2:0], 1'b0} ^ ({CRC_WIDTH{top}} & CRC_POLY);
			end
		end
		return rem;
	endfunction

	assign crc_take  = cap_strobe && (cap_fn == FN_CRC);
	assign rem_start = cap_first ? '0 : crc_rem;
	assign rem_next  = crc_fold(rem_start, cap_byte, cap_last);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			crc_done <= 1'b0;
		end else begin
			crc_done <= crc_take && cap_last;
		end
	end

	// Running remainder doubles as the held result
	always_ff @(posedge clk) begin
		if (crc_take) begin
			crc_rem <= rem_next;
		end
	end

	// Closing bytes come a whole block apart
	a_done_single: assert property (@(posedge clk) disable iff (rst)
		crc_done |=> !crc_done)
		else $error("crc_stage: crc_done high on two cycles in a row");

endmodule

//--- source/gray_stage.sv
`timescale 1ns/1ps

module gray_stage import iotdf_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  cap_strobe,
	input  logic [BYTE_WIDTH-1:0] cap_byte,
	input  logic                  cap_first,
	input  logic                  cap_last,
	input  logic [FN_WIDTH-1:0]   cap_fn,
	output logic                  gray_strobe,
	output logic [BYTE_WIDTH-1:0] gray_byte,
	output logic                  gray_last
);

	logic                  is_b2g;
	logic                  is_g2b;
	logic                  take;
	logic                  carry;
	logic                  carry_in;
	logic [BYTE_WIDTH-1:0] conv;

	assign is_b2g   = (cap_fn == FN_B2G);
	assign is_g2b   = (cap_fn == FN_G2B);
	assign take     = cap_strobe && (is_b2g || is_g2b);
	assign carry_in = cap_first ? 1'b0 : carry;

	// --------------------------------------------------
	// Byte conversion, carry stands in for bit i+1 of the byte above
	// --------------------------------------------------
	always_comb begin
		conv = '0;
		if (is_b2g) begin
			conv = cap_byte ^ {carry_in, cap_byte[BYTE_WIDTH-1:1]};
		end else begin
			conv[BYTE_WIDTH-1] = cap_byte[BYTE_WIDTH-1] ^ carry_in;
			for (int i = BYTE_WIDTH - 2; i >= 0; i--) begin
				conv[i] = cap_byte[i] ^ conv[i+1];
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			carry       <= 1'b0;
			gray_strobe <= 1'b0;
			gray_last   <= 1'b0;
		end else begin
			gray_strobe <= take;
			gray_last   <= take && cap_last;
			if (take) begin
				// Encode chains on input bits, decode on output bits
				carry <= is_b2g ? cap_byte[0] : conv[0];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			gray_byte <= conv;
		end
	end

endmodule

//--- source/iotdf.sv
`timescale 1ns/1ps

module iotdf import iotdf_pkg::*; #(
	parameter logic [CRC_WIDTH-1:0] CRC_POLY = 3'b011
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  in_en,
	input  logic [BYTE_WIDTH-1:0] iot_in,
	input  logic [FN_WIDTH-1:0]   fn_sel,
	output logic                  busy,
	output logic                  valid,
	output result_word_u          iot_out
);

	logic                  cap_strobe;
	logic [BYTE_WIDTH-1:0] cap_byte;
	logic                  cap_first;
	logic                  cap_last;
	logic [FN_WIDTH-1:0]   cap_fn;

	logic                  crc_done;
	logic [CRC_WIDTH-1:0]  crc_rem;

	logic                  gray_strobe;
	logic [BYTE_WIDTH-1:0] gray_byte;
	logic                  gray_last;

	// --------------------------------------------------
	// Stage 1
	// --------------------------------------------------
	byte_capture u_capture (
		.clk        (clk),
		.rst        (rst),
		.in_en      (in_en),
		.iot_in     (iot_in),
		.fn_sel     (fn_sel),
		.busy       (busy),
		.cap_strobe (cap_strobe),
		.cap_byte   (cap_byte),
		.cap_first  (cap_first),
		.cap_last   (cap_last),
		.cap_fn     (cap_fn),
		.cap_idx    ()
	);

	// --------------------------------------------------
	// Stage 2, both units see every captured byte
	// --------------------------------------------------
	crc_stage #(
		.CRC_POLY (CRC_POLY)
	) u_crc (
		.clk        (clk),
		.rst        (rst),
		.cap_strobe (cap_strobe),
		.cap_byte   (cap_byte),
		.cap_first  (cap_first),
		.cap_last   (cap_last),
		.cap_fn     (cap_fn),
		.crc_done   (crc_done),
		.crc_rem    (crc_rem)
	);

	gray_stage u_gray (
		.clk         (clk),
		.rst         (rst),
		.cap_strobe  (cap_strobe),
		.cap_byte    (cap_byte),
		.cap_first   (cap_first),
		.cap_last    (cap_last),
		.cap_fn      (cap_fn),
		.gray_strobe (gray_strobe),
		.gray_byte   (gray_byte),
		.gray_last   (gray_last)
	);

	// Stage 3
	result_assembler u_assembler (
		.clk         (clk),
		.rst         (rst),
		.crc_done    (crc_done),
		.crc_rem     (crc_rem),
		.gray_strobe (gray_strobe),
		.gray_byte   (gray_byte),
		.gray_last   (gray_last),
		.valid       (valid),
		.iot_out     (iot_out)
	);

endmodule

//--- source/iotdf_pkg.sv
package iotdf_pkg;

	// --------------------------------------------------
	// Widths
	// --------------------------------------------------
	localparam int FN_WIDTH       = 3;
	localparam int BYTE_WIDTH     = 8;
	localparam int BLOCK_BYTES    = 16;
	localparam int BYTE_IDX_WIDTH = 4;
	localparam int WORD_WIDTH     = 128;
	localparam int CRC_WIDTH      = 3;

	// Function codes on fn_sel
	// Codes 1 and 2 are accepted but produce no result
	localparam logic [FN_WIDTH-1:0] FN_ENC = 3'd1;
	localparam logic [FN_WIDTH-1:0] FN_DEC = 3'd2;
	localparam logic [FN_WIDTH-1:0] FN_CRC = 3'd3;
	localparam logic [FN_WIDTH-1:0] FN_B2G = 3'd4;
	localparam logic [FN_WIDTH-1:0] FN_G2B = 3'd5;

	// --------------------------------------------------
	// Result word, full Gray word or padded CRC remainder
	// --------------------------------------------------
	typedef union packed {
		logic [WORD_WIDTH-1:0] raw;
		struct packed {
			logic [WORD_WIDTH-CRC_WIDTH-1:0] crc_pad;
			logic [CRC_WIDTH-1:0]            crc_rem;
		} crc_view;
	} result_word_u;

endpackage

//--- source/result_assembler.sv
`timescale 1ns/1ps

module result_assembler import iotdf_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  crc_done,
	input  logic [CRC_WIDTH-1:0]  crc_rem,
	input  logic                  gray_strobe,
	input  logic [BYTE_WIDTH-1:0] gray_byte,
	input  logic                  gray_last,
	output logic                  valid,
	output result_word_u          iot_out
);

	logic [WORD_WIDTH-1:0] gray_shift;
	logic [WORD_WIDTH-1:0] shift_next;
	logic                  gray_close;

	// MSB byte arrives first, so it ends up at the top after 16 shifts
	assign shift_next = {gray_shift[WORD_WIDTH-BYTE_WIDTH-1:0], gray_byte};
	assign gray_close = gray_strobe && gray_last;

	always_ff @(posedge clk) begin
		if (gray_strobe) begin
			gray_shift <= shift_next;
		end
	end

	// --------------------------------------------------
	// Result word, held between valid pulses
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (gray_close) begin
			iot_out.raw <= shift_next;
		end else if (crc_done) begin
			iot_out.crc_view.crc_pad <= '0;
			iot_out.crc_view.crc_rem <= crc_rem;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			valid <= 1'b0;
		end else begin
			valid <= gray_close || crc_done;
		end
	end

	// Only one block closes per cycle at the input
	a_one_source: assert property (@(posedge clk) disable iff (rst)
		!(crc_done && gray_strobe))
		else $error("result_assembler: CRC and Gray results collide");

endmodule
